/* testbench/sec_stimulus.txt */
# op key acc threat | granted locked attempts level kind (hex; op 0 req 1 threat 2 reset)
# key 0 stored 1 wrong; threat bits tamper,power,glitch,rst; kind 0 grant 1 alert 2 none
0 0 5 0 1 0 00 00 0
0 1 2 0 1 0 00 00 2
1 0 0 4 0 0 00 03 1
0 0 3 0 1 0 00 03 0
1 0 0 2 0 0 00 03 1
0 1 1 0 0 0 01 03 2
0 1 1 0 0 0 02 03 2
0 0 7 0 1 0 00 03 0
1 0 0 2 0 0 00 03 1
0 1 0 0 0 0 01 03 2
0 1 0 0 0 0 02 03 2
0 1 0 0 0 1 03 03 2
0 0 9 0 0 1 03 03 2
1 0 0 8 0 1 03 03 2
2 0 0 0 0 0 00 00 2
0 0 4 2 0 0 00 02 1
1 0 0 8 0 1 00 04 1
2 0 0 0 0 0 00 00 2
0 1 0 0 0 0 01 00 2
1 0 0 1 0 1 01 04 1

/* all.f */
logic/sec_cfg_pkg.sv
logic/sec_types_pkg.sv
logic/sec_req_if.sv
logic/sec_event_if.sv
logic/sec_event_decode.sv
logic/sec_access_fsm.sv
logic/sec_audit_log.sv
logic/sdcard_security_top.sv
testbench/tb_sdcard_security.sv

/* testbench/tb_sdcard_security.sv */
// ==================================================
// Testbench for the SD card access-control block.
// Replays testbench/sec_stimulus.txt one operation
// per line and checks access flags, alert level,
// status word and audit records after each one.
// ==================================================
`timescale 1ns/1ps

module tb_sdcard_security import sec_cfg_pkg::*, sec_types_pkg::*; ();

    localparam int RESET_CYCLES  = 10;
    localparam int AUDIT_WAIT    = 8;
    localparam int QUIET_WAIT    = 4;
    localparam int MAX_LINES     = 256;
    // Falling edges from the sampling edge to the audit pulse
    localparam int AUDIT_LATENCY = 3;

    logic                   PCLK_i;
    logic                   PRESETn_i;
    logic [KEY_W-1:0]       auth_key_i;
    logic [USER_ID_W-1:0]   user_id_i;
    logic [ACCESS_W-1:0]    access_level_i;
    logic                   auth_request_i;
    logic                   tamper_detect_i;
    logic                   power_fault_i;
    logic                   clock_glitch_i;
    logic                   reset_attack_i;
    logic                   access_granted_o;
    logic                   security_lock_o;
    logic [ATTEMPT_W-1:0]   auth_attempts_o;
    logic                   security_alert_o;
    breach_level_t          alert_level_o;
    logic [STATUS_W-1:0]    security_status_o;
    logic                   audit_valid_o;
    audit_record_u          audit_record_o;

    // Reference audit sequence and random source
    logic [AUDIT_SEQ_W-1:0] ref_seq;
    logic [15:0]            lfsr_q = 16'd29818;

    sdcard_security_top sdcard_security_top_inst (
        .PCLK_i            (PCLK_i),
        .PRESETn_i         (PRESETn_i),
        .auth_key_i        (auth_key_i),
        .user_id_i         (user_id_i),
        .access_level_i    (access_level_i),
        .auth_request_i    (auth_request_i),
        .tamper_detect_i   (tamper_detect_i),
        .power_fault_i     (power_fault_i),
        .clock_glitch_i    (clock_glitch_i),
        .reset_attack_i    (reset_attack_i),
        .access_granted_o  (access_granted_o),
        .security_lock_o   (security_lock_o),
        .auth_attempts_o   (auth_attempts_o),
        .security_alert_o  (security_alert_o),
        .alert_level_o     (alert_level_o),
        .security_status_o (security_status_o),
        .audit_valid_o     (audit_valid_o),
        .audit_record_o    (audit_record_o)
    );

    initial begin
        PCLK_i = 1'b0;
        forever #5 PCLK_i = ~PCLK_i;
    end

    // ==================================================
    // Failure handling and compares
    // ==================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input breach_level_t exp,
                               input breach_level_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_record(input string name, input audit_record_u exp,
                                input audit_record_u act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [ATTEMPT_W-1:0] exp,
                               input logic [ATTEMPT_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input logic [STATUS_W-1:0] exp,
                                input logic [STATUS_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // ==================================================
    // Stimulus helpers
    // ==================================================
    // Galois LFSR, taps for x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [KEY_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[KEY_W-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Threat bits {tamper, power, glitch, reset attack}, worst first
    function automatic breach_level_t threat_level(input logic [3:0] threat);
        if (threat[3] || threat[0]) return BREACH_CRITICAL;
        if (threat[2]) return BREACH_HIGH;
        if (threat[1]) return BREACH_MED;
        return BREACH_NONE;
    endfunction

    task automatic apply_reset();
        @(posedge PCLK_i);
        PRESETn_i       <= 1'b0;
        auth_request_i  <= 1'b0;
        tamper_detect_i <= 1'b0;
        power_fault_i   <= 1'b0;
        clock_glitch_i  <= 1'b0;
        reset_attack_i  <= 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) @(posedge PCLK_i);
        PRESETn_i <= 1'b1;
        @(negedge PCLK_i);
    endtask

    // One-cycle strobe, sampled on the second edge
    task automatic drive_op(input logic req, input logic [KEY_W-1:0] key,
                            input logic [USER_ID_W-1:0] uid,
                            input logic [ACCESS_W-1:0] acc, input logic [3:0] threat);
        @(posedge PCLK_i);
        auth_key_i      <= key;
        user_id_i       <= uid;
        access_level_i  <= acc;
        auth_request_i  <= req;
        tamper_detect_i <= threat[3];
        power_fault_i   <= threat[2];
        clock_glitch_i  <= threat[1];
        reset_attack_i  <= threat[0];
        @(posedge PCLK_i);
        auth_request_i  <= 1'b0;
        tamper_detect_i <= 1'b0;
        power_fault_i   <= 1'b0;
        clock_glitch_i  <= 1'b0;
        reset_attack_i  <= 1'b0;
    endtask

    // Watch for an audit pulse, sampled on falling edges
    task automatic wait_audit(input int limit, output logic seen, output int at,
                              output audit_record_u rec);
        int cycles;
        seen   = 1'b0;
        rec    = '0;
        at     = 0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge PCLK_i);
            cycles++;
            if (audit_valid_o) begin
                seen = 1'b1;
                at   = cycles;
                rec  = audit_record_o;
            end
        end
    endtask

    // ==================================================
    // One stimulus line
    // ==================================================
    task automatic run_op(input int lineno, input logic [31:0] op, input logic [31:0] key_sel,
                          input logic [31:0] acc, input logic [31:0] threat,
                          input logic [31:0] exp_g, input logic [31:0] exp_l,
                          input logic [31:0] exp_att, input logic [31:0] exp_lvl,
                          input logic [31:0] exp_kind);
        logic [KEY_W-1:0]       key;
        logic [KEY_W-1:0]       bits;
        logic                   seen;
        int                     at;
        audit_record_u          got_rec;
        audit_record_u          exp_rec;
        breach_level_t          lvl;
        logic [STATUS_W-1:0]    exp_status;
        string                  tag;
        tag = $sformatf("line %0d", lineno);
        if (op == 2) begin
            apply_reset();
            ref_seq = '0;
            check_flag({tag, " audit valid"}, 1'b0, audit_valid_o);
            check_record({tag, " audit record"}, '0, audit_record_o);
        end else begin
            draw_bits(USER_ID_W, bits);
            if (key_sel == 0) begin
                key = STORED_AUTH_KEY;
            end else begin
                draw_bits(KEY_W, key);
                // Wrong key must really differ
                if (key == STORED_AUTH_KEY) key[0] = ~key[0];
            end
            drive_op(op == 0, key, bits[USER_ID_W-1:0], acc[ACCESS_W-1:0], threat[3:0]);
            if (exp_kind == 2) begin
                wait_audit(QUIET_WAIT, seen, at, got_rec);
                if (seen) abort_run($sformatf("%s: audit record appeared but none was due", tag));
            end else begin
                wait_audit(AUDIT_WAIT, seen, at, got_rec);
                if (!seen) abort_run($sformatf("%s: no audit record within %0d cycles",
                                               tag, AUDIT_WAIT));
                if (at != AUDIT_LATENCY) begin
                    abort_run($sformatf("%s: audit record came after %0d cycles, not %0d",
                                        tag, at, AUDIT_LATENCY));
                end
                exp_rec = '0;
                if (exp_kind == 0) begin
                    exp_rec.grant.kind         = AUDIT_GRANT;
                    exp_rec.grant.access_level = acc[ACCESS_W-1:0];
                    exp_rec.grant.user_id      = bits[USER_ID_W-1:0];
                    exp_rec.grant.seq          = ref_seq;
                end else begin
                    exp_rec.alert.kind  = AUDIT_ALERT;
                    exp_rec.alert.level = threat_level(threat[3:0]);
                    exp_rec.alert.seq   = ref_seq;
                end
                check_record({tag, " audit record"}, exp_rec, got_rec);
                ref_seq = ref_seq + 1'b1;
            end
        end
        lvl = breach_level_t'(exp_lvl[LEVEL_W-1:0]);
        // Level, low count bits, alert, locked, granted
        exp_status = {exp_lvl[LEVEL_W-1:0], exp_att[STATUS_CNT_W-1:0],
                      lvl != BREACH_NONE, exp_l[0], exp_g[0]};
        check_flag({tag, " granted"}, exp_g[0], access_granted_o);
        check_flag({tag, " locked"}, exp_l[0], security_lock_o);
        check_count({tag, " attempts"}, exp_att[ATTEMPT_W-1:0], auth_attempts_o);
        check_level({tag, " alert level"}, lvl, alert_level_o);
        check_flag({tag, " alert"}, lvl != BREACH_NONE, security_alert_o);
        check_status({tag, " status"}, exp_status, security_status_o);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int             fd;
        int             lineno;
        int             ops;
        int             nread;
        int             nfields;
        string          line;
        logic [31:0]    op, key_sel, acc, threat;
        logic [31:0]    exp_g, exp_l, exp_att, exp_lvl, exp_kind;
        PRESETn_i       = 1'b0;
        auth_key_i      = '0;
        user_id_i       = '0;
        access_level_i  = '0;
        auth_request_i  = 1'b0;
        tamper_detect_i = 1'b0;
        power_fault_i   = 1'b0;
        clock_glitch_i  = 1'b0;
        reset_attack_i  = 1'b0;
        ref_seq         = '0;
        apply_reset();
        fd = $fopen("testbench/sec_stimulus.txt", "r");
        if (fd == 0) abort_run("cannot open the stimulus file testbench/sec_stimulus.txt");
        lineno = 0;
        ops    = 0;
        while (!$feof(fd) && lineno < MAX_LINES) begin
            lineno++;
            nread = $fgets(line, fd);
            // Skip blank and comment lines
            if (nread > 0 && line.len() > 1 && line.getc(0) != "#") begin
                nfields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op, key_sel, acc,
                                  threat, exp_g, exp_l, exp_att, exp_lvl, exp_kind);
                if (nfields != 9) begin
                    abort_run($sformatf("stimulus line %0d has %0d fields, 9 needed",
                                        lineno, nfields));
                end else begin
                    run_op(lineno, op, key_sel, acc, threat, exp_g, exp_l, exp_att,
                           exp_lvl, exp_kind);
                    ops++;
                end
            end
        end
        $fclose(fd);
        if (ops == 0) begin
            abort_run("the stimulus file holds no operations");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* logic/sdcard_security_top.sv */
// ================================================
// Access-control top level. Decode, access FSM and
// audit log in a three-stage pipeline; plain ports.
// ================================================
`timescale 1ns/1ps

module sdcard_security_top import sec_cfg_pkg::*, sec_types_pkg::*; (
    input  logic                    PCLK_i,
    input  logic                    PRESETn_i,
    // Authentication request
    input  logic [KEY_W-1:0]        auth_key_i,
    input  logic [USER_ID_W-1:0]    user_id_i,
    input  logic [ACCESS_W-1:0]     access_level_i,
    input  logic                    auth_request_i,
    // Threat inputs
    input  logic                    tamper_detect_i,
    input  logic                    power_fault_i,
    input  logic                    clock_glitch_i,
    input  logic                    reset_attack_i,
    // Access status
    output logic                    access_granted_o,
    output logic                    security_lock_o,
    output logic [ATTEMPT_W-1:0]    auth_attempts_o,
    // Alerts and audit
    output logic                    security_alert_o,
    output breach_level_t           alert_level_o,
    output logic [STATUS_W-1:0]     security_status_o,
    output logic                    audit_valid_o,
    output audit_record_u           audit_record_o
);

    // Stage links
    sec_req_if      req_bus ();
    sec_event_if    evt_bus ();
    logic           breach_valid;
    breach_level_t  breach_level;

    sec_event_decode u_decode (
        .PCLK_i, .PRESETn_i,
        .auth_key_i, .user_id_i, .access_level_i, .auth_request_i,
        .tamper_detect_i, .power_fault_i, .clock_glitch_i, .reset_attack_i,
        .req            (req_bus),
        .breach_valid_o (breach_valid),
        .breach_level_o (breach_level)
    );

    sec_access_fsm u_fsm (
        .PCLK_i, .PRESETn_i,
        .req            (req_bus),
        .breach_valid_i (breach_valid),
        .breach_level_i (breach_level),
        .evt            (evt_bus),
        .access_granted_o, .security_lock_o, .auth_attempts_o
    );

    sec_audit_log u_audit (
        .PCLK_i, .PRESETn_i,
        .evt            (evt_bus),
        .audit_valid_o, .audit_record_o,
        .security_alert_o, .alert_level_o, .security_status_o
    );

endmodule

/* logic/sec_audit_log.sv */
// ================================================
// Audit log. Turns FSM events into sequenced audit
// records, tracks the worst breach level since
// reset and builds the status word.
// ================================================
`timescale 1ns/1ps

module sec_audit_log import sec_cfg_pkg::*, sec_types_pkg::*; (
    input  logic                    PCLK_i,
    input  logic                    PRESETn_i,
    sec_event_if.audit              evt,
    output logic                    audit_valid_o,
    output audit_record_u           audit_record_o,
    output logic                    security_alert_o,
    output breach_level_t           alert_level_o,
    output logic [STATUS_W-1:0]     security_status_o
);

    logic [AUDIT_SEQ_W-1:0] seq_q;
    breach_level_t          level_d;
    logic                   alert_d;

    // Sticky maximum level
    always_comb begin
        level_d = alert_level_o;
        if (evt.alert_evt && (evt.evt_level > alert_level_o)) begin
            level_d = evt.evt_level;
        end
    end

    assign alert_d = (level_d != BREACH_NONE);

    // ================================================
    // Records, sequence and status
    // ================================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            seq_q             <= '0;
            audit_valid_o     <= 1'b0;
            audit_record_o    <= '0;
            alert_level_o     <= BREACH_NONE;
            security_alert_o  <= 1'b0;
            security_status_o <= '0;
        end else begin
            audit_valid_o    <= evt.grant_evt || evt.alert_evt;
            alert_level_o    <= level_d;
            security_alert_o <= alert_d;
            // Level, low count bits, alert, locked, granted
            security_status_o <= {level_d, evt.fail_count[STATUS_CNT_W-1:0],
                                  alert_d, evt.locked, evt.granted};
            if (evt.grant_evt) begin
                audit_record_o.grant.kind         <= AUDIT_GRANT;
                audit_record_o.grant.pad          <= '0;
                audit_record_o.grant.access_level <= evt.evt_access_level;
                audit_record_o.grant.user_id      <= evt.evt_user_id;
                audit_record_o.grant.seq          <= seq_q;
                seq_q                             <= seq_q + 1'b1;
            end else if (evt.alert_evt) begin
                audit_record_o.alert.kind  <= AUDIT_ALERT;
                audit_record_o.alert.pad   <= '0;
                audit_record_o.alert.level <= evt.evt_level;
                audit_record_o.alert.seq   <= seq_q;
                seq_q                      <= seq_q + 1'b1;
            end
        end
    end

    // One event per cycle from the FSM
    assert property (@(posedge PCLK_i) disable iff (!PRESETn_i)
        !(evt.grant_evt && evt.alert_evt))
        else $error("grant and alert events in one cycle");

endmodule

/* logic/sec_access_fsm.sv */
// ================================================
// Access FSM. Acts on decoded requests and breach
// levels one cycle after decode, keeps the failure
// count and lockout, and emits grant/alert events
// for the audit log.
// ================================================
`timescale 1ns/1ps

module sec_access_fsm import sec_cfg_pkg::*, sec_types_pkg::*; (
    input  logic                    PCLK_i,
    input  logic                    PRESETn_i,
    sec_req_if.fsm                  req,
    input  logic                    breach_valid_i,
    input  breach_level_t           breach_level_i,
    sec_event_if.fsm                evt,
    output logic                    access_granted_o,
    output logic                    security_lock_o,
    output logic [ATTEMPT_W-1:0]    auth_attempts_o
);

    access_state_t          state_q;
    logic [ATTEMPT_W-1:0]   fail_q;
    logic [ATTEMPT_W-1:0]   fail_inc;
    logic                   breach_take;
    logic                   req_take;

    // ================================================
    // Accept conditions
    // ================================================
    // Threats ignored once locked
    assign breach_take = breach_valid_i && (state_q != ST_LOCKED);
    // Requests only from idle, and a threat in the same cycle wins
    assign req_take    = req.req_valid && (state_q == ST_IDLE) && !breach_take;
    assign fail_inc    = fail_q + 1'b1;

    // State, failure count and event strobes
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            state_q       <= ST_IDLE;
            fail_q        <= '0;
            evt.grant_evt <= 1'b0;
            evt.alert_evt <= 1'b0;
        end else begin
            evt.grant_evt <= 1'b0;
            evt.alert_evt <= 1'b0;
            if (breach_take) begin
                evt.alert_evt <= 1'b1;
                // Critical locks, anything else revokes access
                if (breach_level_i == BREACH_CRITICAL) begin
                    state_q <= ST_LOCKED;
                end else begin
                    state_q <= ST_IDLE;
                end
            end else if (req_take) begin
                if (req.key_match) begin
                    state_q       <= ST_GRANTED;
                    fail_q        <= '0;
                    evt.grant_evt <= 1'b1;
                end else begin
                    fail_q <= fail_inc;
                    // Lockout on reaching the limit
                    if (fail_inc >= MAX_AUTH_ATTEMPTS) begin
                        state_q <= ST_LOCKED;
                    end
                end
            end
        end
    end

    // ================================================
    // Event payload
    // ================================================
    always_ff @(posedge PCLK_i) begin
        if (breach_take) begin
            evt.evt_level <= breach_level_i;
        end
        if (req_take && req.key_match) begin
            evt.evt_user_id      <= req.user_id;
            evt.evt_access_level <= req.access_level;
        end
    end

    // Status levels straight from the state register
    assign access_granted_o = (state_q == ST_GRANTED);
    assign security_lock_o  = (state_q == ST_LOCKED);
    assign auth_attempts_o  = fail_q;

    assign evt.granted    = access_granted_o;
    assign evt.locked     = security_lock_o;
    assign evt.fail_count = fail_q;

    // ================================================
    // Checks
    // ================================================
    // Lockout holds until reset, and no access is granted while locked
    assert property (@(posedge PCLK_i) disable iff (!PRESETn_i)
        security_lock_o |=> security_lock_o && !access_granted_o)
        else $error("lock released or access granted while locked");

    // Last allowed failure locks on the next edge and stays locked
    assert property (@(posedge PCLK_i) disable iff (!PRESETn_i)
        (req_take && !req.key_match && fail_inc == MAX_AUTH_ATTEMPTS)
        |=> security_lock_o ##1 security_lock_o)
        else $error("no lockout after maximum failures");

endmodule

/* logic/sec_event_decode.sv */
// ================================================
// Decode stage. Registers the request strobe with
// the key compare result and classifies threat
// inputs into a breach level. Latency one cycle.
// ================================================
`timescale 1ns/1ps

module sec_event_decode import sec_cfg_pkg::*, sec_types_pkg::*; (
    input  logic                    PCLK_i,
    input  logic                    PRESETn_i,
    input  logic [KEY_W-1:0]        auth_key_i,
    input  logic [USER_ID_W-1:0]    user_id_i,
    input  logic [ACCESS_W-1:0]     access_level_i,
    input  logic                    auth_request_i,
    input  logic                    tamper_detect_i,
    input  logic                    power_fault_i,
    input  logic                    clock_glitch_i,
    input  logic                    reset_attack_i,
    sec_req_if.decode               req,
    output logic                    breach_valid_o,
    output breach_level_t           breach_level_o
);

    breach_level_t level_d;

    // ================================================
    // Threat classification
    // ================================================
    always_comb begin
        // Highest severity wins
        if (tamper_detect_i || reset_attack_i) begin
            level_d = BREACH_CRITICAL;
        end else if (power_fault_i) begin
            level_d = BREACH_HIGH;
        end else if (clock_glitch_i) begin
            level_d = BREACH_MED;
        end else begin
            level_d = BREACH_NONE;
        end
    end

    // Control strobes and breach level
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            req.req_valid  <= 1'b0;
            req.key_match  <= 1'b0;
            breach_valid_o <= 1'b0;
            breach_level_o <= BREACH_NONE;
        end else begin
            req.req_valid  <= auth_request_i;
            // Full-width compare against the provisioned key
            req.key_match  <= auth_request_i && (auth_key_i == STORED_AUTH_KEY);
            breach_valid_o <= (level_d != BREACH_NONE);
            breach_level_o <= level_d;
        end
    end

    // Request payload, captured with the strobe
    always_ff @(posedge PCLK_i) begin
        if (auth_request_i) begin
            req.user_id      <= user_id_i;
            req.access_level <= access_level_i;
        end
    end

    // Valid flag tracks a non-zero level one cycle after the threat
    assert property (@(posedge PCLK_i) disable iff (!PRESETn_i)
        (tamper_detect_i || power_fault_i || clock_glitch_i || reset_attack_i)
        |=> breach_valid_o && (breach_level_o != BREACH_NONE))
        else $error("breach_valid_o out of step with breach_level_o");

endmodule

/* logic/sec_event_if.sv */
// ================================================
// Grant/alert events and status levels from the
// access FSM to the audit log.
// ================================================
`timescale 1ns/1ps

interface sec_event_if import sec_cfg_pkg::*, sec_types_pkg::*; ();

    // Strobes, never both high
    logic                   grant_evt;
    logic                   alert_evt;
    // Event payload
    breach_level_t          evt_level;
    logic [USER_ID_W-1:0]   evt_user_id;
    logic [ACCESS_W-1:0]    evt_access_level;
    // Levels
    logic                   granted;
    logic                   locked;
    logic [ATTEMPT_W-1:0]   fail_count;

    modport fsm (
        output grant_evt, alert_evt, evt_level, evt_user_id, evt_access_level,
        output granted, locked, fail_count
    );

    modport audit (
        input  grant_evt, alert_evt, evt_level, evt_user_id, evt_access_level,
        input  granted, locked, fail_count
    );

endinterface

/* logic/sec_req_if.sv */
// ================================================
// Decoded authentication request, from the decode
// stage to the access FSM. One strobe per request.
// ================================================
`timescale 1ns/1ps

interface sec_req_if import sec_cfg_pkg::*; ();

    // One-cycle request strobe
    logic                   req_valid;
    // Presented key equals the stored key
    logic                   key_match;
    // Payload, valid only with req_valid
    logic [USER_ID_W-1:0]   user_id;
    logic [ACCESS_W-1:0]    access_level;

    // Driving side
    modport decode (
        output req_valid,
        output key_match,
        output user_id,
        output access_level
    );

    // Receiving side
    modport fsm (
        input  req_valid,
        input  key_match,
        input  user_id,
        input  access_level
    );

endinterface

/* logic/sec_types_pkg.sv */
// ================================================
// Shared types: access states, breach levels and
// the audit record word with its grant and alert
// views.
// ================================================
package sec_types_pkg;

    import sec_cfg_pkg::*;

    // Access FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_GRANTED,
        ST_LOCKED
    } access_state_t;

    // Breach severity, ordered so a larger code is worse
    typedef enum logic [LEVEL_W-1:0] {
        BREACH_NONE     = LVL_NONE,
        BREACH_MED      = LVL_MED,
        BREACH_HIGH     = LVL_HIGH,
        BREACH_CRITICAL = LVL_CRITICAL
    } breach_level_t;

    // Top bit of every audit record
    typedef enum logic {
        AUDIT_GRANT = 1'b0,
        AUDIT_ALERT = 1'b1
    } audit_kind_t;

    // Grant view
    typedef struct packed {
        audit_kind_t                kind;
        logic [GRANT_PAD_W-1:0]     pad;
        logic [ACCESS_W-1:0]        access_level;
        logic [USER_ID_W-1:0]       user_id;
        logic [AUDIT_SEQ_W-1:0]     seq;
    } audit_grant_t;

    // Alert view
    typedef struct packed {
        audit_kind_t                kind;
        logic [ALERT_PAD_W-1:0]     pad;
        breach_level_t              level;
        logic [AUDIT_SEQ_W-1:0]     seq;
    } audit_alert_t;

    // One audit word, decoded by its kind bit
    typedef union packed {
        audit_grant_t grant;
        audit_alert_t alert;
    } audit_record_u;

endpackage

/* logic/sec_cfg_pkg.sv */
// ================================================
// Sizes, limits and constants for the SD card
// access-control block. Imported by wildcard into
// every stage that needs a width or a limit.
// ================================================
package sec_cfg_pkg;

    // ================================================
    // Field widths
    // ================================================
    localparam int KEY_W        = 256;
    localparam int USER_ID_W    = 8;
    localparam int ACCESS_W     = 4;
    localparam int ATTEMPT_W    = 8;
    localparam int LEVEL_W      = 8;
    localparam int STATUS_W     = 16;
    localparam int STATUS_CNT_W = 5;
    localparam int AUDIT_W      = 32;
    localparam int AUDIT_SEQ_W  = 16;

    // Zero padding inside the two audit record views
    localparam int GRANT_PAD_W = AUDIT_W - 1 - ACCESS_W - USER_ID_W - AUDIT_SEQ_W;
    localparam int ALERT_PAD_W = AUDIT_W - 1 - LEVEL_W - AUDIT_SEQ_W;

    // Failures before lockout
    localparam logic [ATTEMPT_W-1:0] MAX_AUTH_ATTEMPTS = 8'd3;

    // Provisioned authentication key
    localparam logic [KEY_W-1:0] STORED_AUTH_KEY = {
        64'h3C9A_71E4_0B5D_86F2,
        64'hA417_C2E9_5F30_D86B,
        64'h9E21_4C7A_B305_F1D8,
        64'h62BF_0A93_E7C4_158D
    };

    // ================================================
    // Breach level codes
    // ================================================
    localparam logic [LEVEL_W-1:0] LVL_NONE     = 8'h00;
    localparam logic [LEVEL_W-1:0] LVL_MED      = 8'h02;
    localparam logic [LEVEL_W-1:0] LVL_HIGH     = 8'h03;
    localparam logic [LEVEL_W-1:0] LVL_CRITICAL = 8'h04;

endpackage
